// ==== src/memSysPkg.sv ====
`default_nettype none

package memSysPkg;

   // address and data widths of the requester side
   localparam int addrWidth = 16;
   localparam int dataWidth = 16;

   // a byte address is tag, set index and byte offset, from the top down
   localparam int tagWidth = 5;
   localparam int indexWidth = 8;
   localparam int offsetWidth = addrWidth - tagWidth - indexWidth;

   // four words per line, so two bits pick the word inside a line
   localparam int wordsPerLine = 4;
   localparam int wordSelWidth = $clog2(wordsPerLine);

   // cycles from a sampled memory read strobe to its data
   localparam int memLatency = 2;

   typedef logic [addrWidth-1:0] addrT;
   typedef logic [dataWidth-1:0] wordT;
   typedef logic [tagWidth-1:0] tagT;
   typedef logic [indexWidth-1:0] indexT;
   typedef logic [wordSelWidth-1:0] wordSelT;

   // word address into the backing memory made of tag, index and word select
   typedef logic [tagWidth+indexWidth+wordSelWidth-1:0] memAddrT;

   // access sequence of the miss controller
   typedef enum logic [3:0] {
      idle, compareRead, compareWrite,
      evictWord0, evictWord1, evictWord2, evictWord3,
      fetchWord0, fetchWord1, fetchWord2Fill0, fetchWord3Fill1,
      fill2, fill3,
      finalWrite, missDone, hitDone
   } ctrlStateT;

endpackage

`default_nettype wire

// ==== src/cacheWay.sv ====
`default_nettype none

module cacheWay (
   input  wire logic              clk,
   input  wire logic              arstN,
   input  wire memSysPkg::indexT  index,
   input  wire memSysPkg::wordSelT wordSel,
   input  wire memSysPkg::tagT    tagIn,
   input  wire memSysPkg::wordT   writeData,
   input  wire logic              write,
   input  wire logic              fill,
   output memSysPkg::wordT        readData,
   output memSysPkg::tagT         tagOut,
   output logic                   valid,
   output logic                   dirty,
   output logic                   hit
);
   import memSysPkg::*;

   localparam int numSets = 2 ** indexWidth;

   // ####################
   // storage
   // ####################

   // tag, data, valid and dirty storage of all sets
   tagT  tagArray [numSets];
   wordT dataArray [numSets][wordsPerLine];
   logic [numSets-1:0] validBits;
   logic [numSets-1:0] dirtyBits;

   // valid and dirty per set
   // a fill marks the line valid and clean, a plain write marks it dirty
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         validBits <= '0;
         dirtyBits <= '0;
      end else if (write) begin
         if (fill) begin
            validBits[index] <= 1'b1;
            dirtyBits[index] <= 1'b0;
         end else begin
            dirtyBits[index] <= 1'b1;
         end
      end
   end

   // one word per write, the tag is only loaded while a line is filled
   always_ff @(posedge clk) begin
      if (write) begin
         dataArray[index][wordSel] <= writeData;
         if (fill) begin
            tagArray[index] <= tagIn;
         end
      end
   end

   // ####################
   // lookup
   // ####################

   // reads are combinational, the controller decides in the same cycle
   assign readData = dataArray[index][wordSel];
   assign tagOut   = tagArray[index];
   assign valid    = validBits[index];
   assign dirty    = dirtyBits[index];

   // an invalid line never hits, whatever its stale tag holds
   assign hit = valid && (tagOut == tagIn);

endmodule

`default_nettype wire

// ==== src/wayPicker.sv ====
`default_nettype none

module wayPicker (
   input  wire logic            clk,
   input  wire logic            arstN,
   input  wire logic            hit0,
   input  wire logic            hit1,
   input  wire logic            valid0,
   input  wire logic            valid1,
   input  wire logic            dirty0,
   input  wire logic            dirty1,
   input  wire memSysPkg::tagT  tagOut0,
   input  wire memSysPkg::tagT  tagOut1,
   input  wire memSysPkg::wordT readData0,
   input  wire memSysPkg::wordT readData1,
   input  wire logic            capture,
   input  wire logic            advance,
   input  wire logic            wayWrite,
   output logic                 anyHit,
   output logic                 selDirty,
   output memSysPkg::tagT       selTag,
   output memSysPkg::wordT      readData,
   output logic                 write0,
   output logic                 write1
);
   import memSysPkg::*;

   logic victim;
   logic selNow;
   logic selQ;
   logic sel;

   // hit first, then an empty way (way 0 before way 1), then the victim
   always_comb begin
      if (hit0) begin
         selNow = 1'b0;
      end else if (hit1) begin
         selNow = 1'b1;
      end else if (!valid0) begin
         selNow = 1'b0;
      end else if (!valid1) begin
         selNow = 1'b1;
      end else begin
         selNow = victim;
      end
   end

   // during compare the live choice is used, afterwards the captured one
   // so the fill cannot flip the way once the new tag lands in it
   assign sel = capture ? selNow : selQ;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         selQ   <= 1'b0;
         victim <= 1'b0;
      end else begin
         if (capture) begin
            selQ <= selNow;
         end
         // the victim flips once per finished access, hit or miss
         if (advance) begin
            victim <= ~victim;
         end
      end
   end

   assign anyHit   = hit0 | hit1;
   assign selDirty = sel ? dirty1 : dirty0;
   assign selTag   = sel ? tagOut1 : tagOut0;
   assign readData = sel ? readData1 : readData0;

   // only the selected way sees the write strobe
   assign write0 = wayWrite & ~sel;
   assign write1 = wayWrite & sel;

endmodule

`default_nettype wire

// ==== src/missController.sv ====
`default_nettype none

module missController (
   input  wire logic            clk,
   input  wire logic            arstN,
   input  wire memSysPkg::addrT addr,
   input  wire memSysPkg::wordT dataIn,
   input  wire logic            rd,
   input  wire logic            wr,
   input  wire logic            anyHit,
   input  wire logic            selDirty,
   input  wire memSysPkg::tagT  selTag,
   input  wire memSysPkg::wordT memReadData,
   output logic                 done,
   output logic                 stall,
   output logic                 cacheHit,
   output memSysPkg::wordSelT   wordSel,
   output memSysPkg::wordT      wayWriteData,
   output logic                 wayWrite,
   output logic                 wayFill,
   output logic                 capture,
   output logic                 advance,
   output logic                 memRead,
   output logic                 memWrite,
   output memSysPkg::memAddrT   memAddr
);
   import memSysPkg::*;

   ctrlStateT state;
   ctrlStateT nextState;

   // fields of the held request without offset bit 0
   tagT     reqTag;
   indexT   reqIndex;
   wordSelT reqWord;

   // word of the cache line and word and tag of the memory access
   wordSelT lineWord;
   wordSelT memWord;
   tagT     memTag;

   assign reqTag   = addr[addrWidth-1 -: tagWidth];
   assign reqIndex = addr[offsetWidth +: indexWidth];
   assign reqWord  = addr[1 +: wordSelWidth];

   // ####################
   // state sequence
   // ####################

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= idle;
      end else begin
         state <= nextState;
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         // exactly one of rd and wr makes a request
         idle: begin
            if (rd && !wr) begin
               nextState = compareRead;
            end else if (wr && !rd) begin
               nextState = compareWrite;
            end
         end
         compareRead, compareWrite: begin
            if (anyHit) begin
               nextState = hitDone;
            end else if (selDirty) begin
               nextState = evictWord0;
            end else begin
               nextState = fetchWord0;
            end
         end
         evictWord0:      nextState = evictWord1;
         evictWord1:      nextState = evictWord2;
         evictWord2:      nextState = evictWord3;
         evictWord3:      nextState = fetchWord0;
         fetchWord0:      nextState = fetchWord1;
         fetchWord1:      nextState = fetchWord2Fill0;
         fetchWord2Fill0: nextState = fetchWord3Fill1;
         fetchWord3Fill1: nextState = fill2;
         fill2:           nextState = fill3;
         // the request is still held, so wr tells whether a word is left to store
         fill3:           nextState = (wr && !rd) ? finalWrite : missDone;
         finalWrite:      nextState = missDone;
         default:         nextState = idle;
      endcase
   end

   // ####################
   // datapath controls
   // ####################

   always_comb begin
      lineWord     = reqWord;
      memWord      = reqWord;
      memTag       = reqTag;
      wayWriteData = dataIn;
      wayWrite     = 1'b0;
      wayFill      = 1'b0;
      memRead      = 1'b0;
      memWrite     = 1'b0;
      case (state)
         // a write hit stores the word right away, a write miss waits for the fill
         compareWrite: wayWrite = anyHit;
         // the victim line goes back under its own tag, word by word
         evictWord0, evictWord1, evictWord2, evictWord3: begin
            memWrite = 1'b1;
            memTag   = selTag;
            lineWord = wordSelT'(state - evictWord0);
            memWord  = wordSelT'(state - evictWord0);
         end
         fetchWord0, fetchWord1: begin
            memRead = 1'b1;
            memWord = wordSelT'(state - fetchWord0);
         end
         // two reads are in flight here, the older data fills the line
         fetchWord2Fill0, fetchWord3Fill1: begin
            memRead  = 1'b1;
            memWord  = wordSelT'(state - fetchWord0);
            lineWord = wordSelT'(state - fetchWord2Fill0);
         end
         default: begin
         end
      endcase
      case (state)
         fetchWord2Fill0, fetchWord3Fill1, fill2, fill3: begin
            wayWrite     = 1'b1;
            wayFill      = 1'b1;
            wayWriteData = memReadData;
         end
         default: begin
         end
      endcase
      if (state == fill2 || state == fill3) begin
         lineWord = wordSelT'(state - fill2 + 2);
      end
      if (state == finalWrite) begin
         wayWrite = 1'b1;
      end
   end

   assign wordSel = lineWord;
   assign memAddr = {memTag, reqIndex, memWord};

   // ####################
   // requester handshake
   // ####################

   assign done     = (state == hitDone) || (state == missDone);
   assign cacheHit = (state == hitDone);
   assign stall    = !(state == idle || done);

   // selection is frozen when compare ends, the victim moves when done ends
   assign capture = (state == compareRead) || (state == compareWrite);
   assign advance = done;

endmodule

`default_nettype wire

// ==== src/backingMemory.sv ====
`default_nettype none

module backingMemory (
   input  wire logic               clk,
   input  wire logic               arstN,
   input  wire memSysPkg::memAddrT memAddr,
   input  wire memSysPkg::wordT    writeData,
   input  wire logic               read,
   input  wire logic               write,
   output memSysPkg::wordT         readData
);
   import memSysPkg::*;

   localparam int memWords = 2 ** $bits(memAddrT);

   // 32K words that stay undefined until they are written
   wordT memArray [memWords];

   // one address register per cycle of latency
   memAddrT rdAddr [memLatency];
   logic [memLatency-1:0] rdValid;

   // read strobes travel alongside their addresses
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         rdValid <= '0;
      end else begin
         rdValid <= {rdValid[memLatency-2:0], read};
      end
   end

   // a new read can enter every cycle, nothing ever stalls
   always_ff @(posedge clk) begin
      rdAddr[0] <= memAddr;
      for (int i = 1; i < memLatency; i++) begin
         rdAddr[i] <= rdAddr[i-1];
      end
      if (write) begin
         memArray[memAddr] <= writeData;
      end
   end

   // the oldest address reads the array, data shows memLatency cycles after the strobe
   assign readData = rdValid[memLatency-1] ? memArray[rdAddr[memLatency-1]] : '0;

endmodule

`default_nettype wire

// ==== src/memSystem.sv ====
`default_nettype none

module memSystem (
   input  wire logic            clk,
   input  wire logic            arstN,
   input  wire memSysPkg::addrT addr,
   input  wire memSysPkg::wordT dataIn,
   input  wire logic            rd,
   input  wire logic            wr,
   output memSysPkg::wordT      dataOut,
   output logic                 done,
   output logic                 stall,
   output logic                 cacheHit
);
   import memSysPkg::*;

   // ####################
   // internal nets
   // ####################

   // way outputs
   logic hit0, hit1, valid0, valid1, dirty0, dirty1;
   tagT  tagOut0, tagOut1;
   wordT readData0, readData1;

   // picker outputs where the selected word also feeds the memory write port
   logic anyHit, selDirty, write0, write1;
   tagT  selTag;
   wordT selData;

   // controller outputs
   wordSelT wordSel;
   wordT    wayWriteData;
   logic    wayWrite, wayFill, capture, advance, memRead, memWrite;
   memAddrT memAddr;

   // memory read data
   wordT    memReadData;

   assign dataOut = selData;

   cacheWay way0_i (
      .clk(clk), .arstN(arstN),
      .index(addr[offsetWidth +: indexWidth]), .wordSel(wordSel),
      .tagIn(addr[addrWidth-1 -: tagWidth]), .writeData(wayWriteData),
      .write(write0), .fill(wayFill),
      .readData(readData0), .tagOut(tagOut0), .valid(valid0), .dirty(dirty0), .hit(hit0)
   );

   cacheWay way1_i (
      .clk(clk), .arstN(arstN),
      .index(addr[offsetWidth +: indexWidth]), .wordSel(wordSel),
      .tagIn(addr[addrWidth-1 -: tagWidth]), .writeData(wayWriteData),
      .write(write1), .fill(wayFill),
      .readData(readData1), .tagOut(tagOut1), .valid(valid1), .dirty(dirty1), .hit(hit1)
   );

   wayPicker wayPicker_i (
      .clk(clk), .arstN(arstN),
      .hit0(hit0), .hit1(hit1), .valid0(valid0), .valid1(valid1),
      .dirty0(dirty0), .dirty1(dirty1), .tagOut0(tagOut0), .tagOut1(tagOut1),
      .readData0(readData0), .readData1(readData1),
      .capture(capture), .advance(advance), .wayWrite(wayWrite),
      .anyHit(anyHit), .selDirty(selDirty), .selTag(selTag), .readData(selData),
      .write0(write0), .write1(write1)
   );

   missController missController_i (
      .clk(clk), .arstN(arstN),
      .addr(addr), .dataIn(dataIn), .rd(rd), .wr(wr),
      .anyHit(anyHit), .selDirty(selDirty), .selTag(selTag), .memReadData(memReadData),
      .done(done), .stall(stall), .cacheHit(cacheHit),
      .wordSel(wordSel), .wayWriteData(wayWriteData), .wayWrite(wayWrite),
      .wayFill(wayFill), .capture(capture), .advance(advance),
      .memRead(memRead), .memWrite(memWrite), .memAddr(memAddr)
   );

   backingMemory backingMemory_i (
      .clk(clk), .arstN(arstN),
      .memAddr(memAddr), .writeData(selData), .read(memRead), .write(memWrite),
      .readData(memReadData)
   );

endmodule

`default_nettype wire

// ==== verif/memSystemTb.sv ====
`default_nettype none

module memSystemTb;
   timeunit 1ns;
   timeprecision 1ps;

   import memSysPkg::*;

   // cycles an access may take before its done is called missing
   localparam int doneLimit = 40;
   // watchdog budget in cycles for each case
   localparam int cyclesPerCase = 40;

   logic clk;
   logic arstN;
   addrT addr;
   wordT dataIn;
   logic rd;
   logic wr;
   wordT dataOut;
   logic done;
   logic stall;
   logic cacheHit;

   // one entry per line of the case file
   int   opQ[$];
   addrT addrQ[$];
   wordT dataQ[$];
   wordT expQ[$];
   int   hitQ[$];
   int   latQ[$];
   int   caseCount = 0;
   logic casesLoaded = 1'b0;

   int dataErrors = 0;
   int flagErrors = 0;
   int latencyErrors = 0;
   int protocolErrors = 0;
   int fileErrors = 0;
   logic aborted = 1'b0;

   integer seed = 32'he3626083;
   int gap;
   int totalErrors;

   memSystem memSystem_i (
      .clk(clk), .arstN(arstN),
      .addr(addr), .dataIn(dataIn), .rd(rd), .wr(wr),
      .dataOut(dataOut), .done(done), .stall(stall), .cacheHit(cacheHit)
   );

   always #10 clk = ~clk;

   // ####################
   // checks
   // ####################

   task automatic checkWord(input string name, input wordT expected, input wordT actual);
      if (actual !== expected) begin
         dataErrors++;
         $display("[ERROR] %0d ns %s expected %h got %h", $time, name, expected, actual);
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         flagErrors++;
         $display("[ERROR] %0d ns %s expected %b got %b", $time, name, expected, actual);
      end
   endtask

   task automatic printErrorCounts();
      $display("errors: file %0d, data %0d, flag %0d, latency %0d, protocol %0d",
               fileErrors, dataErrors, flagErrors, latencyErrors, protocolErrors);
   endtask

   // ####################
   // case file
   // ####################

   // blank lines and lines starting with # carry no case
   task automatic loadCases();
      int fd;
      string line;
      int count;
      int opV;
      addrT a;
      wordT d;
      wordT e;
      int h;
      int l;
      fd = $fopen("verif/memSystemCases.txt", "r");
      if (fd == 0) begin
         $display("could not open the case file verif/memSystemCases.txt");
         fileErrors++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) == 0) begin
            break;
         end
         if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
            continue;
         end
         count = $sscanf(line, "%h %h %h %h %d %d", opV, a, d, e, h, l);
         if (count != 6) begin
            $display("malformed line in the case file: %s", line);
            fileErrors++;
         end else begin
            opQ.push_back(opV);
            addrQ.push_back(a);
            dataQ.push_back(d);
            expQ.push_back(e);
            hitQ.push_back(h);
            latQ.push_back(l);
         end
      end
      $fclose(fd);
      caseCount = opQ.size();
   endtask

   // ####################
   // one access
   // ####################

   // called at a rising edge, returns at the edge where done was seen high
   task automatic runAccess(input int idx);
      int lat;
      logic seenDone;
      rd     <= (opQ[idx] == 0);
      wr     <= (opQ[idx] != 0);
      addr   <= addrQ[idx];
      dataIn <= dataQ[idx];
      // the controller is still idle until the next edge samples the request
      @(negedge clk);
      checkFlag("done", 1'b0, done);
      checkFlag("stall", 1'b0, stall);
      checkFlag("cacheHit", 1'b0, cacheHit);
      lat = 0;
      seenDone = 1'b0;
      while (!seenDone && lat < doneLimit) begin
         @(negedge clk);
         lat++;
         if (done === 1'b1) begin
            seenDone = 1'b1;
         end else begin
            checkFlag("stall", 1'b1, stall);
            checkFlag("cacheHit", 1'b0, cacheHit);
         end
      end
      if (!seenDone) begin
         $display("case %0d got no done within %0d cycles", idx, doneLimit);
         protocolErrors++;
         aborted = 1'b1;
      end else begin
         if (lat != latQ[idx]) begin
            $display("case %0d took %0d cycles where %0d were expected", idx, lat, latQ[idx]);
            latencyErrors++;
         end
         checkFlag("cacheHit", hitQ[idx] != 0, cacheHit);
         checkFlag("stall", 1'b0, stall);
         // read data only counts for reads
         if (opQ[idx] == 0) begin
            checkWord("dataOut", expQ[idx], dataOut);
         end
         @(posedge clk);
      end
   endtask

   // ####################
   // main sequence
   // ####################

   initial begin
      clk    = 1'b0;
      arstN  = 1'b0;
      addr   = '0;
      dataIn = '0;
      rd     = 1'b0;
      wr     = 1'b0;
      loadCases();
      if (fileErrors != 0 || caseCount == 0) begin
         $display("the case file gave no usable cases");
         printErrorCounts();
         $display("CHECKS FAILED");
         $finish;
      end else begin
         casesLoaded = 1'b1;
         repeat (4) @(posedge clk);
         arstN <= 1'b1;
         // everything is quiet before the first request
         @(negedge clk);
         checkFlag("done", 1'b0, done);
         checkFlag("stall", 1'b0, stall);
         checkFlag("cacheHit", 1'b0, cacheHit);
         @(posedge clk);
         for (int i = 0; i < caseCount && !aborted; i++) begin
            runAccess(i);
            gap = $unsigned($random(seed)) % 4;
            if (!aborted && gap > 0) begin
               rd <= 1'b0;
               wr <= 1'b0;
               // done must drop after one cycle and stay low while idle
               repeat (gap) begin
                  @(negedge clk);
                  checkFlag("done", 1'b0, done);
                  checkFlag("stall", 1'b0, stall);
                  checkFlag("cacheHit", 1'b0, cacheHit);
                  @(posedge clk);
               end
            end
         end
         rd <= 1'b0;
         wr <= 1'b0;
         @(negedge clk);
         checkFlag("done", 1'b0, done);
         checkFlag("cacheHit", 1'b0, cacheHit);
         totalErrors = fileErrors + dataErrors + flagErrors + latencyErrors + protocolErrors;
         printErrorCounts();
         if (totalErrors == 0) begin
            $display("ALL CHECKS PASSED");
         end else begin
            $display("CHECKS FAILED");
         end
         $finish;
      end
   end

   // the budget only starts once the case count is known
   initial begin
      wait (casesLoaded);
      repeat (caseCount * cyclesPerCase) @(posedge clk);
      $display("timeout after %0d cycles, the run did not finish", caseCount * cyclesPerCase);
      printErrorCounts();
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
src/memSysPkg.sv
src/cacheWay.sv
src/wayPicker.sv
src/missController.sv
src/backingMemory.sv
src/memSystem.sv
verif/memSystemTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the cache testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module memSystemTb \
      -f src.f -o memSystemSim; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/memSystemSim)
runStatus=$?
printf '%s\n' "$output"

if [ "$runStatus" -ne 0 ]; then
   echo "simulation exited with status $runStatus"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx 'ALL CHECKS PASSED'; then
   exit 0
fi
echo "simulation did not report success"
exit 1

// ==== verif/memSystemCases.txt ====
# op (0 read, 1 write) addr data expectedData in hex, then expectedHit and expectedLatency
# expectedData is only compared for reads, latency counts cycles until done
1 0880 1111 0000 0 9
0 0880 0000 1111 1 2
1 1082 2222 0000 0 9
0 0880 0000 1111 1 2
0 1082 0000 2222 1 2
1 0880 1a1a 0000 1 2
0 0880 0000 1a1a 1 2
1 1884 3333 0000 0 13
0 1082 0000 2222 0 12
0 0880 0000 1a1a 0 12
0 1884 0000 3333 0 8
0 0880 0000 1a1a 1 2
0 1884 0000 3333 1 2
1 2956 beef 0000 0 9
1 f950 cafe 0000 0 9
0 2956 0000 beef 1 2
1 2952 5a5a 0000 1 2
0 2952 0000 5a5a 1 2
0 f950 0000 cafe 1 2
1 0154 0f0f 0000 0 13
0 f950 0000 cafe 0 12
0 2952 0000 5a5a 0 12
0 2956 0000 beef 1 2
0 0154 0000 0f0f 0 8
